//--- flist.f
+incdir+rtl
rtl/cdac_pkg.sv
rtl/clk1mhz_gen.sv
rtl/comp_thresh_load_fsm.sv
rtl/al_cdac.sv
rtl/al_sequencer.sv
rtl/cdac_top.sv
verif/cdac_sva.sv
verif/cdac_tb.sv

//--- Makefile
# Verilator build and run for the comparator DAC loader

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module cdac_tb -f flist.f \
		-Mdir obj_dir -o cdac_sim

run: compile
	./obj_dir/cdac_sim | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/cdac_patterns.txt
# Columns: name op value expected, values in hex
# burst writes value, its inverse, then expected; random draws its own value
w_mid       write   800  800
w_zero      write   000  000
w_full      write   fff  fff
w_alt       write   a5a  a5a
reload_a5a  reload  000  a5a
w_low       write   001  001
reload_low  reload  000  001
w_msb       write   c3c  c3c
burst_1     burst   123  456
reload_456  reload  000  456
burst_2     burst   7e7  081
w_walk      write   369  369
reload_369  reload  000  369
rand_0      random  000  000
rand_1      random  000  000
rand_2      random  000  000
rand_3      random  000  000
rand_4      random  000  000
rand_5      random  000  000
reload_end  reload  000  000

//--- verif/cdac_tb.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module cdac_tb;

	localparam int MAX_TESTS = 64;
	localparam int WAIT_LIM = 30 * `CDAC_DIV;  // CLK40 cycles, one load and then some

	logic                  CLK40;
	logic                  RST;
	logic                  wr_thresh;
	logic [`CDAC_TH_W-1:0] thr_data;
	logic                  auto_load;
	logic                  clk1mhz;
	logic                  shck_ena;
	logic                  sdata;
	logic                  dac_enb;
	logic                  cdac_done;
	logic                  busy;

	logic [8*32-1:0]       t_name [MAX_TESTS];
	logic [8*32-1:0]       t_op [MAX_TESTS];
	logic [`CDAC_TH_W-1:0] t_val [MAX_TESTS];
	logic [`CDAC_TH_W-1:0] t_exp [MAX_TESTS];
	int                    n_tests;

	logic [`CDAC_FRAME_W-1:0] frames_q[$];  // Decoded frames in order
	logic [`CDAC_FRAME_W-1:0] shreg = '0;
	int                       nbits = 0;
	int                       len_errs = 0;
	int                       errors;
	int                       passed;
	int                       failed;
	int                       cycles = 0;
	int                       cycle_limit;
	logic [31:0]              lcg_state;
	logic [`CDAC_TH_W-1:0]    stored_thr;  // Last threshold written to the DUT

	always #2 CLK40 = ~CLK40;

	cdac_top u_cdac_top (
		.CLK40     (CLK40),
		.RST       (RST),
		.wr_thresh (wr_thresh),
		.thr_data  (thr_data),
		.auto_load (auto_load),
		.clk1mhz   (clk1mhz),
		.shck_ena  (shck_ena),
		.sdata     (sdata),
		.dac_enb   (dac_enb),
		.cdac_done (cdac_done),
		.busy      (busy)
	);

	bind cdac_top cdac_sva u_cdac_sva (
		.CLK40     (CLK40),
		.RST       (RST),
		.clk1mhz   (clk1mhz),
		.req       (seq_req),
		.shck_ena  (shck_ena),
		.dac_enb   (dac_enb),
		.cdac_done (cdac_done),
		.busy      (busy)
	);

	//////////////////////////////////////////////////
	// Serial decoder and run limit
	//////////////////////////////////////////////////

	// sdata moves on falling CLK1MHZ, so the rising edge sees it settled
	always @(posedge clk1mhz) begin
		if (shck_ena) begin
			shreg = {shreg[`CDAC_FRAME_W-2:0], sdata};
			nbits = nbits + 1;
			if (nbits == `CDAC_FRAME_W) begin
				frames_q.push_back(shreg);
				nbits = 0;
			end
		end else if (nbits != 0) begin
			$display("Frame ended after %0d bits instead of %0d", nbits, `CDAC_FRAME_W);
			len_errs = len_errs + 1;
			nbits = 0;
		end
	end

	always @(posedge CLK40) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d CLK40 cycles, run stopped", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Three zero bits, threshold MSB first, one zero bit
	function automatic logic [`CDAC_FRAME_W-1:0] frame_for(input logic [`CDAC_TH_W-1:0] thr);
		return {3'b000, thr, 1'b0};
	endfunction

	task automatic read_patterns();
		int fd;
		int code;
		logic [8*32-1:0] tok;
		logic [8*32-1:0] op;
		logic [8*128-1:0] rest;
		logic [`CDAC_TH_W-1:0] v;
		logic [`CDAC_TH_W-1:0] e;
		fd = $fopen("verif/cdac_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verif/cdac_patterns.txt");
			errors++;
			return;
		end
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#") begin
				code = $fgets(rest, fd);  // Column description
			end else if (n_tests < MAX_TESTS) begin
				code = $fscanf(fd, "%s %h %h", op, v, e);
				t_name[n_tests] = tok;
				t_op[n_tests] = op;
				t_val[n_tests] = v;
				t_exp[n_tests] = e;
				n_tests++;
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
		if (n_tests == 0) begin
			$display("No tests found in verif/cdac_patterns.txt");
			errors++;
		end
	endtask

	task automatic drive_write(input logic [`CDAC_TH_W-1:0] val);
		wr_thresh = 1'b1;
		thr_data = val;
		@(negedge CLK40);
		wr_thresh = 1'b0;
	endtask

	task automatic drive_reload();
		auto_load = 1'b1;
		@(negedge CLK40);
		auto_load = 1'b0;
	endtask

	task automatic wait_busy(input logic level, output bit ok);
		int n;
		n = 0;
		while (busy !== level && n < WAIT_LIM) begin
			@(negedge CLK40);
			n++;
		end
		ok = (busy === level);
	endtask

	task automatic wait_done_low(output bit ok);
		int n;
		n = 0;
		while (cdac_done !== 1'b0 && n < WAIT_LIM) begin
			@(negedge CLK40);
			n++;
		end
		ok = (cdac_done === 1'b0);
	endtask

	// One launch followed by its completion
	task automatic load_and_wait(input logic [8*32-1:0] name);
		bit ok;
		wait_busy(1'b1, ok);
		if (!ok) begin
			$display("%0s: busy never rose after the request", name);
			errors++;
		end
		wait_busy(1'b0, ok);
		if (!ok) begin
			$display("%0s: load did not complete, busy still high", name);
			errors++;
		end else if (cdac_done !== 1'b1 || dac_enb !== 1'b0) begin
			$display("%0s: cdac_done=%b dac_enb=%b after busy fell", name, cdac_done, dac_enb);
			errors++;
		end
	endtask

	task automatic check_frames(input logic [8*32-1:0] name, input int base, input int count,
			input logic [`CDAC_TH_W-1:0] e0, input logic [`CDAC_TH_W-1:0] e1);
		logic [`CDAC_FRAME_W-1:0] got;
		logic [`CDAC_FRAME_W-1:0] want;
		if (frames_q.size() - base != count) begin
			$display("%0s: %0d frames seen, %0d expected", name, frames_q.size() - base, count);
			errors++;
		end else begin
			for (int k = 0; k < count; k++) begin
				got = frames_q[base + k];
				want = frame_for((k == 0) ? e0 : e1);
				if (got !== want) begin
					$display("ERR %0s: frame %0d expected %h actual %h", name, k, want, got);
					errors++;
				end
			end
		end
	endtask

	task automatic finish_test(input logic [8*32-1:0] name, input int err0);
		if (errors + len_errs == err0) begin
			passed++;
			$display("Test %0s: ok", name);
		end else begin
			failed++;
			$display("Test %0s: failed", name);
		end
	endtask

	task automatic check_reset();
		int err0;
		logic [5:0] outs;
		err0 = errors + len_errs;
		outs = {busy, dac_enb, cdac_done, shck_ena, sdata, clk1mhz};
		if (outs !== 6'b0) begin
			$display("ERR reset: busy,dac_enb,cdac_done,shck_ena,sdata,clk1mhz expected %b actual %b",
				6'b0, outs);
			errors++;
		end
		finish_test("reset", err0);
	endtask

	task automatic run_test(input int i);
		int err0;
		int base;
		bit ok;
		logic [`CDAC_TH_W-1:0] val;
		logic [`CDAC_TH_W-1:0] expv;
		err0 = errors + len_errs;
		base = frames_q.size();
		val = t_val[i];
		expv = t_exp[i];
		if (t_op[i] == "write") begin
			drive_write(val);
			stored_thr = val;
			load_and_wait(t_name[i]);
			check_frames(t_name[i], base, 1, expv, expv);
		end else if (t_op[i] == "reload") begin
			drive_reload();
			wait_done_low(ok);  // clr_done rides with the capture
			if (!ok) begin
				$display("%0s: cdac_done never cleared after reload", t_name[i]);
				errors++;
			end
			load_and_wait(t_name[i]);
			check_frames(t_name[i], base, 1, stored_thr, stored_thr);  // Resends last write
		end else if (t_op[i] == "burst") begin
			drive_write(val);
			wait_busy(1'b1, ok);
			drive_write(~val);  // Overwritten by the next write
			drive_write(expv);
			stored_thr = expv;
			load_and_wait(t_name[i]);
			load_and_wait(t_name[i]);  // Pending slot
			check_frames(t_name[i], base, 2, val, expv);
		end else if (t_op[i] == "random") begin
			lcg_state = lcg_next(lcg_state);
			val = lcg_state[27:16];
			drive_write(val);
			stored_thr = val;
			load_and_wait(t_name[i]);
			check_frames(t_name[i], base, 1, val, val);
		end else begin
			$display("%0s: unknown op %0s", t_name[i], t_op[i]);
			errors++;
		end
		finish_test(t_name[i], err0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		CLK40 = 1'b0;
		RST = 1'b1;
		wr_thresh = 1'b0;
		thr_data = '0;
		auto_load = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		n_tests = 0;
		lcg_state = 32'd88;
		stored_thr = '0;
		read_patterns();
		cycle_limit = n_tests * 2 * 20 * `CDAC_DIV + 100 * `CDAC_DIV;

		repeat (8) @(negedge CLK40);
		RST = 1'b0;
		@(negedge CLK40);
		check_reset();

		for (int i = 0; i < n_tests; i++)
			run_test(i);

		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors + len_errs);
		if (errors + len_errs == 0 && failed == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- verif/cdac_sva.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module cdac_sva (
	input logic              CLK40,
	input logic              RST,
	input logic              clk1mhz,
	input cdac_pkg::al_req_t req,
	input logic              shck_ena,
	input logic              dac_enb,
	input logic              cdac_done,
	input logic              busy
);

	int unsigned run_len;  // Consecutive shift clock cycles

	always @(posedge clk1mhz or posedge RST) begin
		if (RST)
			run_len <= 0;
		else if (shck_ena)
			run_len <= run_len + 1;
		else
			run_len <= 0;
	end

	//////////////////////////////////////////////////
	// Serial side
	//////////////////////////////////////////////////

	a_shift_len: assert property (@(posedge clk1mhz) disable iff (RST)
		shck_ena |-> run_len < `CDAC_FRAME_W)
		else $error("shck_ena high for more than %0d CLK1MHZ cycles", `CDAC_FRAME_W);

	//////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////

	a_no_capture_busy: assert property (@(posedge CLK40) disable iff (RST)
		req.capture |-> !$past(busy))
		else $error("capture issued while busy");

	a_reset_low: assert property (@(posedge CLK40)
		$fell(RST) |-> (!cdac_done && !dac_enb))
		else $error("cdac_done or dac_enb high after reset release");

	// busy covers the whole load
	a_busy_covers_load: assert property (@(posedge CLK40) disable iff (RST)
		dac_enb |-> busy)
		else $error("dac_enb high while busy is low");

	a_busy_until_done: assert property (@(posedge CLK40) disable iff (RST)
		$fell(busy) |-> $past(cdac_done))
		else $error("busy dropped without cdac_done");

endmodule

//--- rtl/cdac_top.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module cdac_top (
	input  logic                  CLK40,
	input  logic                  RST,
	input  logic                  wr_thresh,
	input  logic [`CDAC_TH_W-1:0] thr_data,
	input  logic                  auto_load,
	output logic                  clk1mhz,
	output logic                  shck_ena,
	output logic                  sdata,
	output logic                  dac_enb,
	output logic                  cdac_done,
	output logic                  busy
);

	cdac_pkg::al_req_t seq_req;  // Sequencer to loader

	//////////////////////////////////////////////////
	// Shift clock
	//////////////////////////////////////////////////

	clk1mhz_gen u_clk1mhz_gen (
		.CLK40   (CLK40),
		.RST     (RST),
		.CLK1MHZ (clk1mhz)
	);

	//////////////////////////////////////////////////
	// Request path and loader
	//////////////////////////////////////////////////

	al_sequencer u_al_sequencer (
		.CLK40     (CLK40),
		.RST       (RST),
		.wr_thresh (wr_thresh),
		.thr_data  (thr_data),
		.auto_load (auto_load),
		.cdac_done (cdac_done),
		.req       (seq_req),
		.busy      (busy)
	);

	al_cdac u_al_cdac (
		.CLK40     (CLK40),
		.CLK1MHZ   (clk1mhz),
		.RST       (RST),
		.req       (seq_req),
		.shck_ena  (shck_ena),
		.sdata     (sdata),
		.dac_enb   (dac_enb),
		.cdac_done (cdac_done)
	);

endmodule

//--- rtl/al_sequencer.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module al_sequencer (
	input  logic                  CLK40,
	input  logic                  RST,
	input  logic                  wr_thresh,
	input  logic [`CDAC_TH_W-1:0] thr_data,
	input  logic                  auto_load,
	input  logic                  cdac_done,
	output cdac_pkg::al_req_t     req,
	output logic                  busy
);

	localparam int SET_W = $clog2(`CDAC_DIV + 1);

	cdac_pkg::al_op_t      in_op;
	cdac_pkg::al_op_t      pend_op;    // One-deep pending slot
	logic [`CDAC_TH_W-1:0] thr_reg;    // Current threshold
	logic [`CDAC_TH_W-1:0] launch_val;
	logic [SET_W-1:0]      settle;     // Lets the shift FSM see the load level drop
	logic                  done_seen;
	logic                  ready;
	logic                  launch;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////

	// A write in the same cycle as a reload covers both
	assign in_op = wr_thresh ? cdac_pkg::op_write :
		(auto_load ? cdac_pkg::op_reload : cdac_pkg::op_none);

	// cdac_done is stale while our own capture is still in flight
	assign done_seen = busy & cdac_done & ~req.capture;

	// Loader idle and its FSM back in idle
	assign ready = ~busy & (settle == '0);

	// Pending slot first, any new request merges into the same launch
	assign launch = ready &
		((pend_op != cdac_pkg::op_none) | (in_op != cdac_pkg::op_none));

	// Latest written value wins
	assign launch_val = (in_op == cdac_pkg::op_write) ? thr_data : thr_reg;

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			req <= '0;
			busy <= 1'b0;
			pend_op <= cdac_pkg::op_none;
			thr_reg <= '0;
			settle <= '0;
		end else begin
			req.capture <= launch;
			req.clr_done <= launch;  // Same cycle as capture
			if (launch)
				req.value <= launch_val;

			if (in_op == cdac_pkg::op_write)
				thr_reg <= thr_data;

			if (launch)
				busy <= 1'b1;
			else if (done_seen)
				busy <= 1'b0;

			// One full CLK1MHZ period before the next launch
			if (done_seen)
				settle <= SET_W'(`CDAC_DIV);
			else if (settle != '0)
				settle <= settle - 1'b1;

			if (launch)
				pend_op <= cdac_pkg::op_none;
			else if (in_op == cdac_pkg::op_write)
				pend_op <= cdac_pkg::op_write;  // Overwrites a pending reload
			else if (in_op == cdac_pkg::op_reload && pend_op == cdac_pkg::op_none)
				pend_op <= cdac_pkg::op_reload;
		end
	end

endmodule

//--- rtl/al_cdac.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module al_cdac (
	input  logic              CLK40,
	input  logic              CLK1MHZ,
	input  logic              RST,
	input  cdac_pkg::al_req_t req,
	output logic              shck_ena,
	output logic              sdata,
	output logic              dac_enb,
	output logic              cdac_done
);

	// Zero bits ahead of the threshold in the frame
	localparam int PAD_HI = `CDAC_FRAME_W - `CDAC_TH_W - 1;

	logic                    load_cthresh;     // Load in progress
	logic                    load_cthresh_r1;  // Copy on falling CLK1MHZ
	logic                    done;
	logic                    le_load_cthresh;
	logic                    set_done;
	logic [`CDAC_TH_W-1:0]   cthresh_hold;
	logic [`CDAC_FRAME_W-1:0] cth_shft;

	//////////////////////////////////////////////////
	// CLK40 side
	//////////////////////////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			load_cthresh <= 1'b0;
			done <= 1'b0;
		end else begin
			// Capture wins over done since both can meet on a relaunch
			if (req.capture)
				load_cthresh <= 1'b1;
			else if (done)
				load_cthresh <= 1'b0;

			if (req.clr_done)
				done <= 1'b0;
			else if (set_done)
				done <= 1'b1;  // set_done spans many CLK40 cycles
		end
	end

	always_ff @(posedge CLK40) begin
		if (req.capture)
			cthresh_hold <= req.value;
	end

	//////////////////////////////////////////////////
	// CLK1MHZ side
	//////////////////////////////////////////////////

	always_ff @(negedge CLK1MHZ or posedge RST) begin
		if (RST) begin
			load_cthresh_r1 <= 1'b0;
			cth_shft <= '0;
		end else begin
			load_cthresh_r1 <= load_cthresh;
			if (le_load_cthresh)
				cth_shft <= {{PAD_HI{1'b0}}, cthresh_hold, 1'b0};  // Framed word
			else if (shck_ena)
				cth_shft <= {cth_shft[`CDAC_FRAME_W-2:0], 1'b0};  // MSB first
		end
	end

	// First falling edge that sees the load level
	assign le_load_cthresh = load_cthresh & ~load_cthresh_r1;

	comp_thresh_load_fsm u_load_fsm (
		.CLK1MHZ  (CLK1MHZ),
		.RST      (RST),
		.start    (load_cthresh),
		.shft_ena (shck_ena),
		.set_done (set_done)
	);

	assign sdata = cth_shft[`CDAC_FRAME_W-1];
	assign dac_enb = load_cthresh;
	assign cdac_done = done;

endmodule

//--- rtl/comp_thresh_load_fsm.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module comp_thresh_load_fsm (
	input  logic CLK1MHZ,
	input  logic RST,
	input  logic start,     // Load level from the CLK40 side
	output logic shft_ena,
	output logic set_done
);

	localparam int CNT_W = $clog2(`CDAC_FRAME_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`CDAC_FRAME_W - 1);

	cdac_pkg::load_state_t state;
	logic [CNT_W-1:0] bit_cnt;

	//////////////////////////////////////////////////
	// State register on falling CLK1MHZ
	//////////////////////////////////////////////////

	always_ff @(negedge CLK1MHZ or posedge RST) begin
		if (RST) begin
			state <= cdac_pkg::ld_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				cdac_pkg::ld_idle: begin
					// Same edge as the frame load in the loader
					if (start) begin
						state <= cdac_pkg::ld_shift;
						bit_cnt <= '0;
					end
				end
				cdac_pkg::ld_shift: begin
					if (bit_cnt == LAST_BIT)
						state <= cdac_pkg::ld_finish;  // 16th shift edge
					else
						bit_cnt <= bit_cnt + 1'b1;
				end
				cdac_pkg::ld_finish: begin
					// Hold here while start is high so a level cannot retrigger
					if (!start)
						state <= cdac_pkg::ld_idle;
				end
				default: begin
					state <= cdac_pkg::ld_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs decoded from state
	//////////////////////////////////////////////////

	assign shft_ena = (state == cdac_pkg::ld_shift);
	assign set_done = (state == cdac_pkg::ld_finish);  // Lasts one CLK1MHZ period

endmodule

//--- rtl/clk1mhz_gen.sv
`timescale 1ns/10ps
`include "cdac_cfg.svh"

module clk1mhz_gen (
	input  logic CLK40,
	input  logic RST,
	output logic CLK1MHZ
);

	localparam int CNT_W = $clog2(`CDAC_DIV);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(`CDAC_DIV / 2 - 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`CDAC_DIV - 1);

	logic [CNT_W-1:0] div_cnt;

	// Toggle at half count and at wrap for 50 % duty
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			div_cnt <= '0;
			CLK1MHZ <= 1'b0;
		end else begin
			if (div_cnt == LAST_CNT) begin
				div_cnt <= '0;
				CLK1MHZ <= ~CLK1MHZ;  // Falling edge
			end else begin
				div_cnt <= div_cnt + 1'b1;
				if (div_cnt == HALF_CNT)
					CLK1MHZ <= ~CLK1MHZ;  // Rising edge
			end
		end
	end

endmodule

//--- rtl/cdac_pkg.sv
`include "cdac_cfg.svh"

package cdac_pkg;

	//////////////////////////////////////////////////
	// Shift controller
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ld_idle,   // Waiting for load level
		ld_shift,  // Shift clock enabled
		ld_finish  // Done pulse, wait for load level to drop
	} load_state_t;

	//////////////////////////////////////////////////
	// Sequencer requests
	//////////////////////////////////////////////////

	// Contents of the pending slot
	typedef enum logic [1:0] {
		op_none,
		op_write,  // New threshold from host
		op_reload  // Resend stored threshold
	} al_op_t;

	// Sequencer to loader
	typedef struct packed {
		logic                  capture;   // One CLK40 cycle
		logic                  clr_done;  // One CLK40 cycle
		logic [`CDAC_TH_W-1:0] value;
	} al_req_t;

endpackage

//--- rtl/cdac_cfg.svh
`ifndef CDAC_CFG_SVH
`define CDAC_CFG_SVH

//////////////////////////////////////////////////
// Comparator DAC load sizes
//////////////////////////////////////////////////

// Threshold register width
`define CDAC_TH_W 12

// Serial word to the DAC
// three zero bits, threshold, one zero bit
`define CDAC_FRAME_W 16

// CLK40 cycles per CLK1MHZ period
`define CDAC_DIV 40

`endif
